//--- files.f
+incdir+hw
hw/pwo_pkg.sv
hw/pwo_ram.sv
hw/pwo_host_port.sv
hw/pwo_ctrl.sv
hw/pwo_alu.sv
hw/pwo_writeback.sv
hw/pwo_wrapper.sv
testbench/pwo_tb.sv

//--- Bender.yml
package:
  name: pwo

export_include_dirs:
  - hw

sources:
  - files:
      - hw/pwo_pkg.sv
      - hw/pwo_ram.sv
      - hw/pwo_host_port.sv
      - hw/pwo_ctrl.sv
      - hw/pwo_alu.sv
      - hw/pwo_writeback.sv
      - hw/pwo_wrapper.sv
  - target: test
    files:
      - testbench/pwo_tb.sv

//--- testbench/pwo_tb.sv
/*
 * Directed testbench of the pointwise engine
 * Shadow memory model, operation tasks, watchdog and report
 */

`timescale 1ns/100ps

`include "pwo_consts.svh"

module pwo_tb
    import pwo_pkg::*;
();

    localparam int     N           = `PWO_N;
    localparam longint Q           = `PWO_Q;
    localparam int     OP_LIMIT    = 20 * N;
    // Six tests of at most 20*N cycles, 8 ns each
    localparam int     WATCHDOG_NS = 6 * 20 * N * 8;

    logic                    clk;
    logic                    rst_n;
    logic                    zeroize;
    logic                    enable;
    pwo_mode_t               mode;
    logic                    accumulate;
    logic                    sampler_mode;
    logic                    sampler_valid;
    logic [`PWO_COEFF_W-1:0] sampler_data;
    logic [`PWO_ADDR_W-1:0]  base_a, base_b, base_c;
    logic                    load_en;
    pwo_mem_sel_t            load_mem;
    logic [`PWO_ADDR_W-1:0]  load_addr;
    logic [`PWO_COEFF_W-1:0] load_data;
    logic                    rd_en;
    logic [`PWO_ADDR_W-1:0]  rd_addr;
    logic [`PWO_COEFF_W-1:0] rd_data;
    logic                    busy;
    logic                    done;

    // Shadow copies of memories A, B and C
    logic [`PWO_COEFF_W-1:0] model_a [2**`PWO_ADDR_W];
    logic [`PWO_COEFF_W-1:0] model_b [2**`PWO_ADDR_W];
    logic [`PWO_COEFF_W-1:0] model_c [2**`PWO_ADDR_W];
    // Next polynomial to load, and the sampler stream
    logic [`PWO_COEFF_W-1:0] stage [N];
    logic [`PWO_COEFF_W-1:0] samp_words [N];

    int cycle_cnt = 0;
    int start_cnt = 0;
    int done_count = 0;
    int test_errs = 0;
    int err_count = 0;
    int failed_tests = 0;

    pwo_wrapper pwo_wrapper_inst (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .enable(enable), .mode(mode), .accumulate(accumulate),
        .sampler_mode(sampler_mode), .sampler_valid(sampler_valid),
        .sampler_data(sampler_data),
        .base_a(base_a), .base_b(base_b), .base_c(base_c),
        .load_en(load_en), .load_mem(load_mem), .load_addr(load_addr), .load_data(load_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .busy(busy), .done(done)
    );

    //======================================================================
    // Clock, cycle counter, done monitor, watchdog
    //======================================================================
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Done is a registered pulse, stable at the falling edge
    always @(negedge clk) begin
        if (done === 1'b1) begin
            done_count = done_count + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    //======================================================================
    // Stimulus helpers
    //======================================================================
    function automatic logic [`PWO_COEFF_W-1:0] rand_coeff();
        return `PWO_COEFF_W'($urandom % Q);
    endfunction

    // Just below q-1, within span
    function automatic logic [`PWO_COEFF_W-1:0] near_top(input int span);
        return `PWO_COEFF_W'(Q - 1 - ($urandom % span));
    endfunction

    // Host writes of stage[] into one memory, shadow updated alongside
    task automatic load_poly(input pwo_mem_sel_t sel, input int base);
        for (int i = 0; i < N; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_mem  <= sel;
            load_addr <= `PWO_ADDR_W'(base + i);
            load_data <= stage[i];
            case (sel)
                mem_a:   model_a[base + i] = stage[i];
                mem_b:   model_b[base + i] = stage[i];
                default: model_c[base + i] = stage[i];
            endcase
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic start_op(input pwo_mode_t m, input logic acc, input logic samp,
                            input int ba, input int bb, input int bc);
        @(posedge clk);
        start_cnt     = cycle_cnt;
        enable       <= 1'b1;
        mode         <= m;
        accumulate   <= acc;
        sampler_mode <= samp;
        base_a       <= `PWO_ADDR_W'(ba);
        base_b       <= `PWO_ADDR_W'(bb);
        base_c       <= `PWO_ADDR_W'(bc);
        @(posedge clk);
        enable <= 1'b0;
    endtask

    // Latency counts rising edges from the enable edge to done
    task automatic wait_done(input string name, output int latency);
        int waited;
        waited  = 0;
        latency = -1;
        while (latency < 0 && waited < OP_LIMIT) begin
            @(negedge clk);
            if (done === 1'b1) begin
                latency = cycle_cnt - start_cnt - 1;
            end else begin
                waited++;
            end
        end
        if (latency < 0) begin
            $display("** Error test=%s: done did not arrive within %0d cycles", name, OP_LIMIT);
            test_errs++;
        end
    endtask

    // Expected C from the mod-q rules
    task automatic apply_model(input pwo_mode_t m, input logic acc, input logic samp,
                               input int ba, input int bb, input int bc);
        longint a;
        longint b;
        longint r;
        for (int i = 0; i < N; i++) begin
            a = model_a[ba + i];
            b = samp ? samp_words[i] : model_b[bb + i];
            case (m)
                pwm:     r = (a * b) % Q;
                pwa:     r = (a + b) % Q;
                default: r = (a - b + Q) % Q;
            endcase
            if (acc) begin
                r = (r + model_c[bc + i]) % Q;
            end
            model_c[bc + i] = r[`PWO_COEFF_W-1:0];
        end
    endtask

    task automatic read_check(input string name, input int base);
        for (int i = 0; i < N; i++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= `PWO_ADDR_W'(base + i);
            @(posedge clk);
            rd_en <= 1'b0;
            @(negedge clk);
            if (rd_data !== model_c[base + i]) begin
                $display("** Error test=%s index=%0d expected=%0d actual=%0d",
                         name, base + i, model_c[base + i], rd_data);
                test_errs++;
            end
        end
    endtask

    task automatic check_latency(input string name, input int lat);
        if (lat != N + 5) begin
            $display("** Error test=%s latency expected=%0d actual=%0d", name, N + 5, lat);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            failed_tests++;
        end
        err_count += test_errs;
        test_errs = 0;
    endtask

    // One word per cycle of valid, random gaps between words
    task automatic feed_sampler();
        int gap;
        while (busy !== 1'b1) begin
            @(negedge clk);
        end
        for (int i = 0; i < N; i++) begin
            gap = $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                sampler_valid <= 1'b0;
                sampler_data  <= rand_coeff();   // junk, must not be taken
            end
            @(posedge clk);
            sampler_valid <= 1'b1;
            sampler_data  <= samp_words[i];
        end
        @(posedge clk);
        sampler_valid <= 1'b0;
    endtask

    //======================================================================
    // Tests
    //======================================================================
    task automatic add_with_wrap();
        int lat;
        // Status after reset
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("** Error test=add: busy or done not low after reset");
            test_errs++;
        end
        // Even elements sum to q or more
        for (int i = 0; i < N; i++) stage[i] = (i % 2 == 0) ? near_top(4096) : rand_coeff();
        load_poly(mem_a, 0);
        for (int i = 0; i < N; i++) stage[i] = (i % 2 == 0) ? near_top(4096) : rand_coeff();
        load_poly(mem_b, 16);
        start_op(pwa, 1'b0, 1'b0, 0, 16, 0);
        wait_done("add", lat);
        apply_model(pwa, 1'b0, 1'b0, 0, 16, 0);
        check_latency("add", lat);
        read_check("add", 0);
        finish_test("add");
    endtask

    task automatic sub_with_borrow();
        int lat;
        // Every third element borrows
        for (int i = 0; i < N; i++) begin
            stage[i] = (i % 3 == 0) ? `PWO_COEFF_W'($urandom % 1000) : rand_coeff();
        end
        load_poly(mem_a, 16);
        for (int i = 0; i < N; i++) stage[i] = (i % 3 == 0) ? near_top(1000) : rand_coeff();
        load_poly(mem_b, 32);
        start_op(pws, 1'b0, 1'b0, 16, 32, 16);
        wait_done("sub", lat);
        apply_model(pws, 1'b0, 1'b0, 16, 32, 16);
        check_latency("sub", lat);
        read_check("sub", 16);
        finish_test("sub");
    endtask

    task automatic mul_near_q();
        int lat;
        for (int i = 0; i < N; i++) stage[i] = (i < 12) ? near_top(64) : rand_coeff();
        load_poly(mem_a, 32);
        for (int i = 0; i < N; i++) stage[i] = (i < 12) ? near_top(64) : rand_coeff();
        load_poly(mem_b, 48);
        start_op(pwm, 1'b0, 1'b0, 32, 48, 48);
        wait_done("mul", lat);
        apply_model(pwm, 1'b0, 1'b0, 32, 48, 48);
        check_latency("mul", lat);
        read_check("mul", 48);
        finish_test("mul");
    endtask

    task automatic mul_accumulate();
        int lat;
        for (int i = 0; i < N; i++) stage[i] = rand_coeff();
        load_poly(mem_c, 32);
        for (int i = 0; i < N; i++) stage[i] = near_top(100000);
        load_poly(mem_a, 48);
        for (int i = 0; i < N; i++) stage[i] = rand_coeff();
        load_poly(mem_b, 0);
        start_op(pwm, 1'b1, 1'b0, 48, 0, 32);
        wait_done("acc", lat);
        apply_model(pwm, 1'b1, 1'b0, 48, 0, 32);
        check_latency("acc", lat);
        read_check("acc", 32);
        // Neighbouring polynomials untouched
        read_check("acc", 0);
        read_check("acc", 16);
        read_check("acc", 48);
        finish_test("acc");
    endtask

    task automatic sampler_stream();
        int lat;
        int d0;
        for (int i = 0; i < N; i++) stage[i] = rand_coeff();
        load_poly(mem_a, 0);
        for (int i = 0; i < N; i++) samp_words[i] = rand_coeff();
        d0 = done_count;
        fork
            begin
                start_op(pwa, 1'b0, 1'b1, 0, 0, 0);
                wait_done("sampler", lat);
            end
            feed_sampler();
        join
        repeat (8) @(posedge clk);
        if (done_count - d0 != 1) begin
            $display("** Error test=sampler done pulses expected=1 actual=%0d", done_count - d0);
            test_errs++;
        end
        apply_model(pwa, 1'b0, 1'b1, 0, 0, 0);
        read_check("sampler", 0);
        finish_test("sampler");
    endtask

    task automatic busy_and_zeroize();
        int lat;
        int d0;
        logic [`PWO_COEFF_W-1:0] junk;
        for (int i = 0; i < N; i++) stage[i] = rand_coeff();
        load_poly(mem_a, 16);
        for (int i = 0; i < N; i++) stage[i] = rand_coeff();
        load_poly(mem_b, 16);
        junk = `PWO_COEFF_W'((model_c[0] + 1) % Q);
        d0 = done_count;
        start_op(pwa, 1'b0, 1'b0, 16, 16, 16);
        repeat (3) @(posedge clk);
        // Second start and a host load into C, both while busy
        enable    <= 1'b1;
        mode      <= pws;
        base_c    <= `PWO_ADDR_W'(48);
        load_en   <= 1'b1;
        load_mem  <= mem_c;
        load_addr <= '0;
        load_data <= junk;
        @(posedge clk);
        enable  <= 1'b0;
        load_en <= 1'b0;
        wait_done("zeroize", lat);
        apply_model(pwa, 1'b0, 1'b0, 16, 16, 16);
        check_latency("zeroize", lat);
        read_check("zeroize", 16);
        read_check("zeroize", 0);
        if (done_count - d0 != 1) begin
            $display("** Error test=zeroize done pulses expected=1 actual=%0d", done_count - d0);
            test_errs++;
        end

        // Abort part way through the issue phase
        d0 = done_count;
        start_op(pwa, 1'b0, 1'b0, 0, 16, 48);
        // Busy rises at the edge that takes enable
        @(negedge clk);
        if (busy !== 1'b1) begin
            $display("** Error test=zeroize: busy not high after enable");
            test_errs++;
        end
        repeat (6) @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b0) begin
            $display("** Error test=zeroize: busy still high after zeroize");
            test_errs++;
        end
        repeat (2 * N) @(posedge clk);
        if (done_count != d0) begin
            $display("** Error test=zeroize: done pulsed after an aborted operation");
            test_errs++;
        end

        // Same region again, now to completion
        start_op(pwa, 1'b0, 1'b0, 0, 16, 48);
        wait_done("zeroize", lat);
        apply_model(pwa, 1'b0, 1'b0, 0, 16, 48);
        check_latency("zeroize", lat);
        read_check("zeroize", 48);
        finish_test("zeroize");
    endtask

    //======================================================================
    // Main sequence
    //======================================================================
    initial begin
        void'($urandom(32'h3c3ac950));
        rst_n         = 1'b0;
        zeroize       = 1'b0;
        enable        = 1'b0;
        mode          = pwa;
        accumulate    = 1'b0;
        sampler_mode  = 1'b0;
        sampler_valid = 1'b0;
        sampler_data  = '0;
        base_a        = '0;
        base_b        = '0;
        base_c        = '0;
        load_en       = 1'b0;
        load_mem      = mem_a;
        load_addr     = '0;
        load_data     = '0;
        rd_en         = 1'b0;
        rd_addr       = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        add_with_wrap();
        sub_with_borrow();
        mul_near_q();
        mul_accumulate();
        sampler_stream();
        busy_and_zeroize();

        $display("Summary: 6 tests, %0d failed, %0d errors", failed_tests, err_count);
        if (failed_tests == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- hw/pwo_wrapper.sv
/*
 * Top level of the pointwise engine
 * Memories A, B, C with host port, controller, ALU and writeback
 */

`timescale 1ns/100ps

`include "pwo_consts.svh"

module pwo_wrapper
    import pwo_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    zeroize,
    // Operation control
    input  logic                    enable,
    input  pwo_mode_t               mode,
    input  logic                    accumulate,
    input  logic                    sampler_mode,
    input  logic                    sampler_valid,
    input  logic [`PWO_COEFF_W-1:0] sampler_data,
    input  logic [`PWO_ADDR_W-1:0]  base_a,
    input  logic [`PWO_ADDR_W-1:0]  base_b,
    input  logic [`PWO_ADDR_W-1:0]  base_c,
    // Host loads
    input  logic                    load_en,
    input  pwo_mem_sel_t            load_mem,
    input  logic [`PWO_ADDR_W-1:0]  load_addr,
    input  logic [`PWO_COEFF_W-1:0] load_data,
    // Host readback of C
    input  logic                    rd_en,
    input  logic [`PWO_ADDR_W-1:0]  rd_addr,
    output logic [`PWO_COEFF_W-1:0] rd_data,
    // Status
    output logic                    busy,
    output logic                    done
);

    //======================================================================
    // Wires
    //======================================================================
    // Memory ports
    logic                    a_wr_en, b_wr_en, c_wr_en;
    logic [`PWO_ADDR_W-1:0]  c_wr_addr, c_rd_addr_m;
    logic [`PWO_COEFF_W-1:0] c_wr_data;
    logic                    c_rd_en_m;
    logic [`PWO_COEFF_W-1:0] a_data, b_data;

    // Controller to memories and ALU
    logic                    eng_rd_en;
    logic [`PWO_ADDR_W-1:0]  a_addr, b_addr, c_rd_addr;
    logic                    issue_valid;
    logic [`PWO_ADDR_W-1:0]  issue_c_addr;
    pwo_mode_t               op_mode;
    logic                    op_acc, op_sampler;

    // ALU to writeback, writeback to memory C
    logic                    res_valid;
    logic [`PWO_COEFF_W-1:0] res_data;
    logic [`PWO_ADDR_W-1:0]  res_c_addr;
    logic                    wb_en;
    logic [`PWO_ADDR_W-1:0]  wb_addr;
    logic [`PWO_COEFF_W-1:0] wb_data;

    //======================================================================
    // Instances
    //======================================================================
    pwo_host_port host_port_inst (
        .load_en(load_en), .load_mem(load_mem), .load_addr(load_addr), .load_data(load_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .busy(busy),
        .eng_c_rd_en(eng_rd_en), .c_rd_addr(c_rd_addr),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .a_wr_en(a_wr_en), .b_wr_en(b_wr_en), .c_wr_en(c_wr_en),
        .c_wr_addr(c_wr_addr), .c_wr_data(c_wr_data),
        .c_rd_en_m(c_rd_en_m), .c_rd_addr_m(c_rd_addr_m)
    );

    // A and B are written by the host only
    pwo_ram mem_a (
        .clk(clk), .wr_en(a_wr_en), .wr_addr(load_addr), .wr_data(load_data),
        .rd_en(eng_rd_en), .rd_addr(a_addr), .rd_data(a_data)
    );

    pwo_ram mem_b (
        .clk(clk), .wr_en(b_wr_en), .wr_addr(load_addr), .wr_data(load_data),
        .rd_en(eng_rd_en), .rd_addr(b_addr), .rd_data(b_data)
    );

    // C read data feeds both the host and the accumulate path
    pwo_ram mem_c (
        .clk(clk), .wr_en(c_wr_en), .wr_addr(c_wr_addr), .wr_data(c_wr_data),
        .rd_en(c_rd_en_m), .rd_addr(c_rd_addr_m), .rd_data(rd_data)
    );

    pwo_ctrl ctrl_inst (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize), .enable(enable), .mode(mode),
        .accumulate(accumulate), .sampler_mode(sampler_mode), .sampler_valid(sampler_valid),
        .base_a(base_a), .base_b(base_b), .base_c(base_c), .last_done(done),
        .busy(busy), .eng_rd_en(eng_rd_en),
        .a_addr(a_addr), .b_addr(b_addr), .c_rd_addr(c_rd_addr),
        .issue_valid(issue_valid), .issue_c_addr(issue_c_addr),
        .op_mode(op_mode), .op_acc(op_acc), .op_sampler(op_sampler)
    );

    pwo_alu alu_inst (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .issue_valid(issue_valid), .issue_c_addr(issue_c_addr),
        .op_mode(op_mode), .op_acc(op_acc), .op_sampler(op_sampler),
        .a_data(a_data), .b_data(b_data), .sampler_data(sampler_data), .c_old(rd_data),
        .res_valid(res_valid), .res_data(res_data), .res_c_addr(res_c_addr)
    );

    pwo_writeback writeback_inst (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .res_valid(res_valid), .res_data(res_data), .res_c_addr(res_c_addr),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data), .done(done)
    );

endmodule

//--- hw/pwo_writeback.sv
/*
 * Result writeback into memory C, write count and done pulse
 */

`timescale 1ns/100ps

`include "pwo_consts.svh"

module pwo_writeback (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    zeroize,
    input  logic                    res_valid,
    input  logic [`PWO_COEFF_W-1:0] res_data,
    input  logic [`PWO_ADDR_W-1:0]  res_c_addr,
    output logic                    wb_en,
    output logic [`PWO_ADDR_W-1:0]  wb_addr,
    output logic [`PWO_COEFF_W-1:0] wb_data,
    output logic                    done
);

    logic [$clog2(`PWO_N)-1:0] wr_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en  <= 1'b0;
            wr_cnt <= '0;
            done   <= 1'b0;
        end else if (zeroize) begin
            // Aborted op ends without done
            wb_en  <= 1'b0;
            wr_cnt <= '0;
            done   <= 1'b0;
        end else begin
            wb_en <= res_valid;
            done  <= 1'b0;
            if (wb_en) begin
                if (wr_cnt == (`PWO_N - 1)) begin
                    wr_cnt <= '0;
                    done   <= 1'b1;   // cycle after the last write
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= res_c_addr;
        wb_data <= res_data;
    end

    // The N-th write of an operation is its last one
    last_write_done: assert property (@(posedge clk) disable iff (!rst_n) done |-> !wb_en)
        else $error("pwo_writeback: write in the done cycle");

endmodule

//--- hw/pwo_alu.sv
/*
 * Three-stage pointwise ALU
 * Modular multiply, add, subtract and optional accumulate
 */

`timescale 1ns/100ps

`include "pwo_consts.svh"

module pwo_alu
    import pwo_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    zeroize,
    input  logic                    issue_valid,
    input  logic [`PWO_ADDR_W-1:0]  issue_c_addr,
    input  pwo_mode_t               op_mode,
    input  logic                    op_acc,
    input  logic                    op_sampler,
    input  logic [`PWO_COEFF_W-1:0] a_data,
    input  logic [`PWO_COEFF_W-1:0] b_data,
    input  logic [`PWO_COEFF_W-1:0] sampler_data,
    input  logic [`PWO_COEFF_W-1:0] c_old,
    output logic                    res_valid,
    output logic [`PWO_COEFF_W-1:0] res_data,
    output logic [`PWO_ADDR_W-1:0]  res_c_addr
);

    localparam int W = `PWO_COEFF_W;

    // Stage 1, memory outputs plus the sampler word taken at issue
    logic                   s1_valid;
    logic [`PWO_ADDR_W-1:0] s1_c_addr;
    logic [W-1:0]           s1_samp;
    logic [W-1:0]           b_op;
    logic [W:0]             sum_raw;
    logic [W-1:0]           sum_mod;
    logic [W-1:0]           diff_mod;
    logic [2*W-1:0]         s2_next;

    // Stage 2, product or corrected sum/difference
    logic                   s2_valid;
    logic [`PWO_ADDR_W-1:0] s2_c_addr;
    logic [2*W-1:0]         s2_val;
    logic [W-1:0]           s2_c_old;

    // Stage 3, Barrett and accumulate
    logic [2*W+23:0]        bar_prod;
    logic [23:0]            bar_q;
    logic [W+1:0]           bar_rem;
    logic [W-1:0]           red;
    logic [W:0]             acc_raw;
    logic [W-1:0]           acc_mod;

    //======================================================================
    // Valid pipe
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else if (zeroize) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            s2_valid  <= s1_valid;
            res_valid <= s2_valid;
        end
    end

    //======================================================================
    // Data pipe
    //======================================================================
    // A and C arrive from the memory read registers in stage 1
    assign b_op = op_sampler ? s1_samp : b_data;

    assign sum_raw  = a_data + b_op;
    assign sum_mod  = (sum_raw >= `PWO_Q) ? W'(sum_raw - `PWO_Q) : sum_raw[W-1:0];
    // Borrow folds back by adding q
    assign diff_mod = (a_data >= b_op) ? (a_data - b_op) : (a_data + `PWO_Q - b_op);

    always_comb begin
        case (op_mode)
            pwm:     s2_next = a_data * b_op;
            pwa:     s2_next = {{W{1'b0}}, sum_mod};
            pws:     s2_next = {{W{1'b0}}, diff_mod};
            default: s2_next = '0;
        endcase
    end

    // Estimate the quotient, one subtract left afterwards
    assign bar_prod = s2_val * `PWO_BARRETT_M;
    assign bar_q    = bar_prod[2*W+23:`PWO_BARRETT_K];
    assign bar_rem  = (W+2)'(s2_val - bar_q * `PWO_Q);

    always_comb begin
        if (op_mode == pwm) begin
            red = (bar_rem >= `PWO_Q) ? W'(bar_rem - `PWO_Q) : bar_rem[W-1:0];
        end else begin
            red = s2_val[W-1:0];
        end
    end

    assign acc_raw = red + s2_c_old;
    assign acc_mod = (acc_raw >= `PWO_Q) ? W'(acc_raw - `PWO_Q) : acc_raw[W-1:0];

    always_ff @(posedge clk) begin
        s1_samp    <= sampler_data;
        s1_c_addr  <= issue_c_addr;
        s2_val     <= s2_next;
        s2_c_old   <= c_old;
        s2_c_addr  <= s1_c_addr;
        res_data   <= op_acc ? acc_mod : red;
        res_c_addr <= s2_c_addr;
    end

    // Every result leaves fully reduced
    res_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> res_data < `PWO_Q)
        else $error("pwo_alu: result not below q");

endmodule

//--- hw/pwo_ctrl.sv
/*
 * Controller FSM of the pointwise engine
 * Latches the operation, issues operand reads, waits for the last write
 */

`timescale 1ns/100ps

`include "pwo_consts.svh"

module pwo_ctrl
    import pwo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   zeroize,
    input  logic                   enable,
    input  pwo_mode_t              mode,
    input  logic                   accumulate,
    input  logic                   sampler_mode,
    input  logic                   sampler_valid,
    input  logic [`PWO_ADDR_W-1:0] base_a,
    input  logic [`PWO_ADDR_W-1:0] base_b,
    input  logic [`PWO_ADDR_W-1:0] base_c,
    input  logic                   last_done,
    output logic                   busy,
    output logic                   eng_rd_en,
    output logic [`PWO_ADDR_W-1:0] a_addr,
    output logic [`PWO_ADDR_W-1:0] b_addr,
    output logic [`PWO_ADDR_W-1:0] c_rd_addr,
    output logic                   issue_valid,
    output logic [`PWO_ADDR_W-1:0] issue_c_addr,
    output pwo_mode_t              op_mode,
    output logic                   op_acc,
    output logic                   op_sampler
);

    pwo_state_t             state;
    logic [`PWO_ADDR_W-1:0] idx;
    logic [`PWO_ADDR_W-1:0] base_a_q;
    logic [`PWO_ADDR_W-1:0] base_b_q;
    logic [`PWO_ADDR_W-1:0] base_c_q;

    //======================================================================
    // FSM and element counter
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            idx        <= '0;
            op_mode    <= pwm;
            op_acc     <= 1'b0;
            op_sampler <= 1'b0;
            base_a_q   <= '0;
            base_b_q   <= '0;
            base_c_q   <= '0;
        end else if (zeroize) begin
            // Abort, nothing left to finish
            state <= idle;
            idx   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (enable) begin
                        state      <= issue;
                        idx        <= '0;
                        op_mode    <= mode;
                        op_acc     <= accumulate;
                        op_sampler <= sampler_mode;
                        base_a_q   <= base_a;
                        base_b_q   <= base_b;
                        base_c_q   <= base_c;
                    end
                end
                issue: begin
                    if (issue_valid) begin
                        idx <= idx + 1'b1;
                        if (idx == (`PWO_N - 1)) begin
                            state <= drain;
                        end
                    end
                end
                drain: begin
                    // Up to four elements still in flight
                    if (last_done) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Sampler gaps stall issue only
    assign issue_valid = (state == issue) && (!op_sampler || sampler_valid);
    assign eng_rd_en   = issue_valid;

    assign a_addr       = base_a_q + idx;
    assign b_addr       = base_b_q + idx;
    assign c_rd_addr    = base_c_q + idx;
    assign issue_c_addr = base_c_q + idx;

    // Low in the done cycle already
    assign busy = (state != idle) && !last_done;

    // No element issued once the writeback has finished
    issue_in_issue: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> (state == issue) && !last_done)
        else $error("pwo_ctrl: issue outside the issue state");

endmodule

//--- hw/pwo_host_port.sv
/*
 * Host load decode and memory C port sharing
 */

`timescale 1ns/100ps

`include "pwo_consts.svh"

module pwo_host_port
    import pwo_pkg::*;
(
    // Host load strobe
    input  logic                    load_en,
    input  pwo_mem_sel_t            load_mem,
    input  logic [`PWO_ADDR_W-1:0]  load_addr,
    input  logic [`PWO_COEFF_W-1:0] load_data,
    // Host readback of C
    input  logic                    rd_en,
    input  logic [`PWO_ADDR_W-1:0]  rd_addr,
    // Engine side
    input  logic                    busy,
    input  logic                    eng_c_rd_en,
    input  logic [`PWO_ADDR_W-1:0]  c_rd_addr,
    input  logic                    wb_en,
    input  logic [`PWO_ADDR_W-1:0]  wb_addr,
    input  logic [`PWO_COEFF_W-1:0] wb_data,
    // Memory strobes
    output logic                    a_wr_en,
    output logic                    b_wr_en,
    output logic                    c_wr_en,
    output logic [`PWO_ADDR_W-1:0]  c_wr_addr,
    output logic [`PWO_COEFF_W-1:0] c_wr_data,
    output logic                    c_rd_en_m,
    output logic [`PWO_ADDR_W-1:0]  c_rd_addr_m
);

    logic host_ok;

    // Loads during an operation are dropped
    assign host_ok = load_en && !busy;

    assign a_wr_en = host_ok && (load_mem == mem_a);
    assign b_wr_en = host_ok && (load_mem == mem_b);

    // Memory C belongs to the engine while busy
    assign c_wr_en     = busy ? wb_en   : (host_ok && (load_mem == mem_c));
    assign c_wr_addr   = busy ? wb_addr : load_addr;
    assign c_wr_data   = busy ? wb_data : load_data;
    assign c_rd_en_m   = busy ? eng_c_rd_en : rd_en;
    assign c_rd_addr_m = busy ? c_rd_addr   : rd_addr;

    // Writeback only ever fires inside an operation
    always_comb begin
        wb_in_busy: assert #0 (wb_en !== 1'b1 || busy !== 1'b0)
            else $error("pwo_host_port: writeback while idle");
    end

endmodule

//--- hw/pwo_ram.sv
/*
 * Coefficient memory, one write port and one registered read port
 */

`timescale 1ns/100ps

`include "pwo_consts.svh"

module pwo_ram (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic [`PWO_ADDR_W-1:0]  wr_addr,
    input  logic [`PWO_COEFF_W-1:0] wr_data,
    input  logic                    rd_en,
    input  logic [`PWO_ADDR_W-1:0]  rd_addr,
    output logic [`PWO_COEFF_W-1:0] rd_data
);

    // 64 x 23 array, contents kept across reset
    logic [`PWO_COEFF_W-1:0] mem [2**`PWO_ADDR_W];

    // Synchronous write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data one cycle after the strobe, held otherwise
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // A write must land on a known word
    wr_addr_known: assert property (@(posedge clk) wr_en === 1'b1 |-> !$isunknown(wr_addr))
        else $error("pwo_ram: write with unknown address");

endmodule

//--- hw/pwo_pkg.sv
/*
 * Shared types of the pointwise engine
 * Operation modes, host memory select and controller states
 */

package pwo_pkg;

    // Pointwise operation selected by the host
    typedef enum logic [1:0] {
        pwm = 2'd0,
        pwa = 2'd1,
        pws = 2'd2
    } pwo_mode_t;

    // Target memory of a host load
    typedef enum logic [1:0] {
        mem_a = 2'd0,
        mem_b = 2'd1,
        mem_c = 2'd2
    } pwo_mem_sel_t;

    // Controller FSM
    typedef enum logic [1:0] {
        idle  = 2'd0,
        issue = 2'd1,
        drain = 2'd2
    } pwo_state_t;

endpackage

//--- hw/pwo_consts.svh
/*
 * Constants for the pointwise polynomial engine
 * Modulus, Barrett factors, polynomial length and widths
 */

`ifndef PWO_CONSTS_SVH
`define PWO_CONSTS_SVH

// ML-DSA prime, 2^23 - 2^13 + 1
`define PWO_Q 23'd8380417

// One coefficient per memory word
`define PWO_COEFF_W 23

// Coefficients per polynomial
`define PWO_N 16

// 64 words, room for four polynomials
`define PWO_ADDR_W 6

// Barrett reduction of a 46-bit product
// M = floor(2^K / q), leaves the remainder below 2q
`define PWO_BARRETT_K 46
`define PWO_BARRETT_M 24'd8396807

`endif
